// ==== all.f ====
+incdir+source
source/noc_pkg.sv
source/input_router.sv
source/output_allocator.sv
source/router_slice_top.sv
dv/tb_router_slice.sv

// ==== dv/tb_router_slice.sv ====
// router slice testbench: directed and random flits on both inputs, checked against a routing model
`timescale 1ns/1ps
`include "noc_config.svh"

module tb_router_slice import noc_pkg::*; ();

  localparam int X_ID = 1;
  localparam int Y_ID = 2;
  localparam int PW   = `NOC_PAYLOAD_W;

  // one flit as the source presents it, gap = idle cycles before it
  typedef struct packed {
    flit_type_t          ftype;
    vc_id_t              vc;
    logic [`NOC_X_W-1:0] x;
    logic [`NOC_Y_W-1:0] y;
    logic [PW-1:0]       payload;
    logic [3:0]          gap;
  } flit_t;

  // flit expected on an output port one cycle after its grant
  typedef struct packed {
    logic [2:0]    port;
    vc_id_t        vc;
    logic [PW-1:0] payload;
  } exp_t;

  logic               clk;
  logic               arst;
  logic               grant_w;
  logic               grant_loc;
  logic [N_PORTS-1:0] out_valid;
  vc_id_t             out_vc [N_PORTS];
  logic [PW-1:0]      out_pay [N_PORTS];
  logic [N_PORTS-1:0] out_src;

  // source side, index 0 west, 1 local
  flit_t      cur [2];
  logic [1:0] busy;
  logic [1:0] consumed;
  int         idle_cnt [2];
  flit_t      src_q [2][$];
  exp_t       exp_q [2][$];

  // reference state: per-input vc route tables, per-port pointers
  int                 route_tbl [2][`NOC_N_VC];
  logic [N_PORTS-1:0] ptr;
  logic [N_PORTS-1:0] exp_mask;

  int seed;
  int errors;
  int n_checks;
  int total_flits;
  int seq_no;
  int cycles;
  int queued [2];
  int delivered [2];

  always #2 clk = ~clk;

  router_slice_top #(
    .ROUTER_X_ID (X_ID),
    .ROUTER_Y_ID (Y_ID)
  ) dut (
    .clk                 (clk),
    .arst                (arst),
    .valid_w_i           (busy[0]),
    .ftype_w_i           (cur[0].ftype),
    .vc_w_i              (cur[0].vc),
    .xdest_w_i           (cur[0].x),
    .ydest_w_i           (cur[0].y),
    .payload_w_i         (cur[0].payload),
    .valid_loc_i         (busy[1]),
    .ftype_loc_i         (cur[1].ftype),
    .vc_loc_i            (cur[1].vc),
    .xdest_loc_i         (cur[1].x),
    .ydest_loc_i         (cur[1].y),
    .payload_loc_i       (cur[1].payload),
    .grant_w_o           (grant_w),
    .grant_loc_o         (grant_loc),
    .out_valid_north_o   (out_valid[P_NORTH]),
    .out_valid_south_o   (out_valid[P_SOUTH]),
    .out_valid_west_o    (out_valid[P_WEST]),
    .out_valid_east_o    (out_valid[P_EAST]),
    .out_valid_local_o   (out_valid[P_LOCAL]),
    .out_vc_north_o      (out_vc[P_NORTH]),
    .out_vc_south_o      (out_vc[P_SOUTH]),
    .out_vc_west_o       (out_vc[P_WEST]),
    .out_vc_east_o       (out_vc[P_EAST]),
    .out_vc_local_o      (out_vc[P_LOCAL]),
    .out_payload_north_o (out_pay[P_NORTH]),
    .out_payload_south_o (out_pay[P_SOUTH]),
    .out_payload_west_o  (out_pay[P_WEST]),
    .out_payload_east_o  (out_pay[P_EAST]),
    .out_payload_local_o (out_pay[P_LOCAL]),
    .out_src_north_o     (out_src[P_NORTH]),
    .out_src_south_o     (out_src[P_SOUTH]),
    .out_src_west_o      (out_src[P_WEST]),
    .out_src_east_o      (out_src[P_EAST]),
    .out_src_local_o     (out_src[P_LOCAL])
  );

  task automatic check(input string name, input logic [PW-1:0] got, input logic [PW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s: expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // expected output port of a flit on input s
  function automatic int ref_port(input int s, input flit_t f);
    // body and tail replay the route of their vc
    if (f.ftype != HEAD_FLIT) begin
      return route_tbl[s][f.vc];
    end
    if ((f.x == X_ID) && (f.y == Y_ID)) begin
      return P_LOCAL;
    end
    // x already matches, move in y
    if (f.x == X_ID) begin
      return (f.y < Y_ID) ? P_WEST : P_EAST;
    end
    return (f.x > X_ID) ? P_SOUTH : P_NORTH;
  endfunction

  task automatic add_flit(input int s, input flit_type_t ft, input int vc, input int x,
                          input int y, input int gap);
    flit_t f;
    f.ftype   = ft;
    f.vc      = vc_id_t'(vc);
    f.x       = x[`NOC_X_W-1:0];
    f.y       = y[`NOC_Y_W-1:0];
    // source and sequence number up top, random low half
    f.payload = {4'(s), 12'(seq_no), 16'($random(seed))};
    f.gap     = 4'(gap);
    seq_no++;
    src_q[s].push_back(f);
    queued[s]++;
    total_flits++;
  endtask

  // two heads on vc 0 and 1, then interleaved body/tail with junk dest fields
  task automatic table_stream(input int s, input int xa, input int ya, input int xb, input int yb);
    add_flit(s, HEAD_FLIT, 0, xa, ya, 0);
    add_flit(s, HEAD_FLIT, 1, xb, yb, 0);
    add_flit(s, BODY_FLIT, 0, rand_below(4), rand_below(4), 0);
    add_flit(s, BODY_FLIT, 1, rand_below(4), rand_below(4), 1);
    add_flit(s, BODY_FLIT, 1, rand_below(4), rand_below(4), 0);
    add_flit(s, BODY_FLIT, 0, rand_below(4), rand_below(4), 0);
    add_flit(s, TAIL_FLIT, 1, rand_below(4), rand_below(4), 2);
    add_flit(s, TAIL_FLIT, 0, rand_below(4), rand_below(4), 0);
  endtask

  task automatic random_packet(input int s);
    int len;
    int vc;
    len = 1 + rand_below(4);
    vc  = rand_below(`NOC_N_VC);
    add_flit(s, HEAD_FLIT, vc, rand_below(4), rand_below(4), rand_below(4));
    for (int i = 1; i < len; i++) begin
      if (i == len - 1) begin
        add_flit(s, TAIL_FLIT, vc, rand_below(4), rand_below(4), rand_below(4));
      end else begin
        add_flit(s, BODY_FLIT, vc, rand_below(4), rand_below(4), rand_below(4));
      end
    end
  endtask

  // until both sources are drained and nothing is in flight
  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while ((src_q[0].size() != 0) || (src_q[1].size() != 0) || (busy != 2'b00) ||
               (exp_q[0].size() != 0) || (exp_q[1].size() != 0));
    repeat (2) @(posedge clk);
  endtask

  // sources: drop a flit once granted, load the next after its gap
  always @(negedge clk) begin
    for (int s = 0; s < 2; s++) begin
      if (consumed[s]) begin
        busy[s]     = 1'b0;
        consumed[s] = 1'b0;
      end
      if (!busy[s] && (src_q[s].size() > 0)) begin
        if (idle_cnt[s] < src_q[s][0].gap) begin
          idle_cnt[s]++;
        end else begin
          cur[s]      = src_q[s].pop_front();
          idle_cnt[s] = 0;
          busy[s]     = 1'b1;
        end
      end
    end
  end

  // compare, 1 ns before the rising edge, where grants and outputs are settled
  always @(negedge clk) begin
    int         req_port [2];
    logic [1:0] exp_gnt;
    logic [1:0] dut_gnt;
    logic [N_PORTS-1:0] next_mask;
    exp_t       e;
    #1;
    dut_gnt = {grant_loc, grant_w};
    if (arst) begin
      check("out_valid", out_valid, '0);
      check("grant", dut_gnt, '0);
      ptr      = '0;
      exp_mask = '0;
      for (int s = 0; s < 2; s++) begin
        for (int v = 0; v < `NOC_N_VC; v++) begin
          route_tbl[s][v] = P_NORTH;
        end
      end
    end else begin
      // last cycle's winners show up now
      check("out_valid", out_valid, exp_mask);
      for (int p = 0; p < N_PORTS; p++) begin
        if (out_valid[p]) begin
          if (exp_q[out_src[p]].size() == 0) begin
            errors++;
            $display("at %0t port %0d delivered a flit that input %0d never had granted",
                     $time, p, out_src[p]);
          end else begin
            e = exp_q[out_src[p]].pop_front();
            check($sformatf("out_port(src %0d)", out_src[p]), p, e.port);
            check($sformatf("out_vc[%0d]", p), out_vc[p], e.vc);
            check($sformatf("out_payload[%0d]", p), out_pay[p], e.payload);
            delivered[out_src[p]]++;
          end
        end
      end
      // predict this cycle's grants
      exp_gnt   = '0;
      next_mask = '0;
      for (int s = 0; s < 2; s++) begin
        req_port[s] = busy[s] ? ref_port(s, cur[s]) : -1;
      end
      if ((busy == 2'b11) && (req_port[0] == req_port[1])) begin
        exp_gnt[ptr[req_port[0]]] = 1'b1;
      end else begin
        exp_gnt = busy;
      end
      check("grant_w_o", dut_gnt[0], exp_gnt[0]);
      check("grant_loc_o", dut_gnt[1], exp_gnt[1]);
      for (int s = 0; s < 2; s++) begin
        if (exp_gnt[s]) begin
          // pointer goes to the other input
          ptr[req_port[s]]       = (s == 0);
          next_mask[req_port[s]] = 1'b1;
          e.port    = 3'(req_port[s]);
          e.vc      = cur[s].vc;
          e.payload = cur[s].payload;
          exp_q[s].push_back(e);
          if (cur[s].ftype == HEAD_FLIT) begin
            route_tbl[s][cur[s].vc] = req_port[s];
          end
        end
      end
      exp_mask = next_mask;
    end
    consumed = dut_gnt;
  end

  // watchdog, budget grows with the flits queued so far
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > total_flits * 10 + 200) begin
        $display("timeout: traffic not drained after %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
      end
    end
  end

  initial begin
    clk          = 1'b0;
    arst         = 1'b1;
    busy         = '0;
    consumed     = '0;
    cur[0]       = '0;
    cur[1]       = '0;
    idle_cnt[0]  = 0;
    idle_cnt[1]  = 0;
    queued[0]    = 0;
    queued[1]    = 0;
    delivered[0] = 0;
    delivered[1] = 0;
    seed         = 32'hdfc0_1a3d;
    errors       = 0;
    n_checks     = 0;
    total_flits  = 0;
    seq_no       = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst = 1'b0;
    @(posedge clk);
    // single heads to every node of the 4x4 mesh
    for (int x = 0; x < 4; x++) begin
      for (int y = 0; y < 4; y++) begin
        add_flit(0, HEAD_FLIT, rand_below(`NOC_N_VC), x, y, 1);
        add_flit(1, HEAD_FLIT, rand_below(`NOC_N_VC), x, y, 2);
      end
    end
    wait_idle();
    // west: vc0 south, vc1 east; local: vc0 north, vc1 west
    table_stream(0, 3, 0, 1, 3);
    table_stream(1, 0, 1, 1, 0);
    wait_idle();
    // both on the west port, back to back
    for (int i = 0; i < 8; i++) begin
      add_flit(0, HEAD_FLIT, 0, 1, 0, 0);
      add_flit(1, HEAD_FLIT, 1, 1, 0, 0);
    end
    wait_idle();
    // south and local side by side
    for (int i = 0; i < 6; i++) begin
      add_flit(0, HEAD_FLIT, 0, 3, 0, 0);
      add_flit(1, HEAD_FLIT, 1, X_ID, Y_ID, 0);
    end
    wait_idle();
    for (int k = 0; k < 6; k++) begin
      random_packet(0);
      random_packet(1);
    end
    wait_idle();
    check("delivered_w", delivered[0], queued[0]);
    check("delivered_loc", delivered[1], queued[1]);
    $display("checks: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the router slice testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_router_slice -o sim_router_slice \
  && ./obj_dir/sim_router_slice > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
  || echo "simulation failed" && exit 1

// ==== source/input_router.sv ====
// input router: x-y next hop decode for head flits, per-vc route replay for body and tail flits
`timescale 1ns/1ps
`include "noc_config.svh"

module input_router import noc_pkg::*; #(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  logic                clk,
  input  logic                arst,
  input  logic                valid_i,
  input  flit_type_t          ftype_i,
  input  vc_id_t              vc_i,
  input  logic [`NOC_X_W-1:0] xdest_i,
  input  logic [`NOC_Y_W-1:0] ydest_i,
  input  logic                grant_i,
  output port_req_t           req_o
);

  // own coordinates at destination field width
  localparam logic [`NOC_X_W-1:0] MY_X = ROUTER_X_ID[`NOC_X_W-1:0];
  localparam logic [`NOC_Y_W-1:0] MY_Y = ROUTER_Y_ID[`NOC_Y_W-1:0];

  // route taken by the last granted head flit of each vc
  route_t route_table [`NOC_N_VC];

  route_t head_route;
  route_t sel_route;
  logic   is_head;
  logic   table_wr;

  assign is_head = valid_i && (ftype_i == HEAD_FLIT);

  // only a consumed head flit updates the table
  // a waiting head keeps decoding from its own fields
  assign table_wr = is_head && grant_i;

  // dimension ordered routing, x first then y
  always_comb begin
    if ((xdest_i == MY_X) && (ydest_i == MY_Y)) begin
      // arrived
      head_route = LOCAL_PORT;
    end else if (xdest_i == MY_X) begin
      // x done, move along y
      if (ydest_i < MY_Y) begin
        head_route = WEST_PORT;
      end else begin
        head_route = EAST_PORT;
      end
    end else begin
      // still adjusting x
      if (xdest_i > MY_X) begin
        head_route = SOUTH_PORT;
      end else begin
        head_route = NORTH_PORT;
      end
    end
  end

  // body and tail ignore their dest fields, follow the stored route
  assign sel_route = is_head ? head_route : route_table[vc_i];

  // route to one-hot request, nothing while idle
  always_comb begin
    req_o = '0;
    if (valid_i) begin
      case (sel_route)
        NORTH_PORT: req_o[P_NORTH] = 1'b1;
        SOUTH_PORT: req_o[P_SOUTH] = 1'b1;
        WEST_PORT:  req_o[P_WEST]  = 1'b1;
        EAST_PORT:  req_o[P_EAST]  = 1'b1;
        LOCAL_PORT: req_o[P_LOCAL] = 1'b1;
        default:    req_o = '0;
      endcase
    end
  end

  // per-vc route table, cleared to north
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      for (int v = 0; v < `NOC_N_VC; v++) begin
        route_table[v] <= NORTH_PORT;
      end
    end else if (table_wr) begin
      route_table[vc_i] <= head_route;
    end
  end

  // request is one-hot exactly while the input holds a flit,
  // including body flits whose stored entry came from an earlier head
  a_req_onehot: assert property (
    @(posedge clk) disable iff (arst)
    valid_i ? $onehot(req_o) : (req_o == '0)
  ) else $error("input_router: request vector not one-hot with valid");

endmodule

// ==== source/noc_config.svh ====
// noc slice configuration: virtual channel count, mesh coordinate widths, flit payload width
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// virtual channels per input
// also sets route table depth and vc id width
`define NOC_N_VC 2

// mesh coordinate widths
// 2 bits each covers a 4x4 mesh
`define NOC_X_W 2
`define NOC_Y_W 2

// flit payload bits
`define NOC_PAYLOAD_W 32

`endif

// ==== source/noc_pkg.sv ====
// noc types shared by the router slice: flit kinds, routes, request vectors, vc ids
`include "noc_config.svh"

package noc_pkg;

  // number of output ports on a mesh router
  localparam int N_PORTS = 5;

  // vc id width, kept at one bit minimum
  localparam int VC_W = (`NOC_N_VC > 1) ? $clog2(`NOC_N_VC) : 1;

  // request vector bit positions
  // same order as the route encoding below
  localparam int P_NORTH = 0;
  localparam int P_SOUTH = 1;
  localparam int P_WEST  = 2;
  localparam int P_EAST  = 3;
  localparam int P_LOCAL = 4;

  // flit kind carried on ftype
  typedef enum logic [1:0] {
    HEAD_FLIT = 2'd0,
    BODY_FLIT = 2'd1,
    TAIL_FLIT = 2'd2
  } flit_type_t;

  // next hop, as stored in the per-vc route table
  // north is zero so a cleared table points north
  typedef enum logic [2:0] {
    NORTH_PORT = 3'd0,
    SOUTH_PORT = 3'd1,
    WEST_PORT  = 3'd2,
    EAST_PORT  = 3'd3,
    LOCAL_PORT = 3'd4
  } route_t;

  // one request bit per output port
  typedef logic [N_PORTS-1:0] port_req_t;

  // virtual channel index
  typedef logic [VC_W-1:0] vc_id_t;

endpackage

// ==== source/output_allocator.sv ====
// output allocator: per-port round-robin between west and local inputs, registered flit output
`timescale 1ns/1ps
`include "noc_config.svh"

module output_allocator import noc_pkg::*; (
  input  logic                                   clk,
  input  logic                                   arst,
  input  port_req_t                              req_w_i,
  input  port_req_t                              req_loc_i,
  input  vc_id_t                                 vc_w_i,
  input  vc_id_t                                 vc_loc_i,
  input  logic [`NOC_PAYLOAD_W-1:0]              payload_w_i,
  input  logic [`NOC_PAYLOAD_W-1:0]              payload_loc_i,
  output logic                                   grant_w_o,
  output logic                                   grant_loc_o,
  output port_req_t                              out_valid_o,
  output vc_id_t [N_PORTS-1:0]                   out_vc_o,
  output logic [N_PORTS-1:0][`NOC_PAYLOAD_W-1:0] out_payload_o,
  output logic [N_PORTS-1:0]                     out_src_o
);

  // priority pointer per port
  // 0 west first, 1 local first
  logic [N_PORTS-1:0] prio_loc;

  // winners per port
  logic [N_PORTS-1:0] win_w;
  logic [N_PORTS-1:0] win_loc;
  logic [N_PORTS-1:0] win_any;

  // two-way round robin per output port
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      // a sole requester wins
      // on conflict the pointer decides
      win_w[p]   = req_w_i[p] && (!req_loc_i[p] || !prio_loc[p]);
      win_loc[p] = req_loc_i[p] && (!req_w_i[p] || prio_loc[p]);
    end
  end

  assign win_any = win_w | win_loc;

  // requests are one-hot so an input wins at most one port
  // grant is a level that the source holds its flit against
  assign grant_w_o   = |win_w;
  assign grant_loc_o = |win_loc;

  // pointer and output valid
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      prio_loc    <= '0;
      out_valid_o <= '0;
    end else begin
      // one cycle pulse per granted flit
      out_valid_o <= win_any;
      for (int p = 0; p < N_PORTS; p++) begin
        // pointer moves to the input that lost or did not ask
        if (win_any[p]) begin
          prio_loc[p] <= win_w[p];
        end
      end
    end
  end

  // flit output stage loaded only on a win
  always_ff @(posedge clk) begin
    for (int p = 0; p < N_PORTS; p++) begin
      if (win_any[p]) begin
        out_vc_o[p]      <= win_loc[p] ? vc_loc_i : vc_w_i;
        out_payload_o[p] <= win_loc[p] ? payload_loc_i : payload_w_i;
        // source tag is 0 for west and 1 for local
        out_src_o[p]     <= win_loc[p];
      end
    end
  end

  // no port is given to both inputs in one cycle
  a_one_winner: assert property (
    @(posedge clk) disable iff (arst)
    (win_w & win_loc) == '0
  ) else $error("output_allocator: both inputs won the same port");

  // grants only go to inputs that present a request
  a_grant_has_req: assert property (
    @(posedge clk) disable iff (arst)
    (!grant_w_o || (req_w_i != '0)) && (!grant_loc_o || (req_loc_i != '0))
  ) else $error("output_allocator: grant without request");

endmodule

// ==== source/router_slice_top.sv ====
// router slice top: west and local input routers feeding one five-port output allocator
`timescale 1ns/1ps
`include "noc_config.svh"

module router_slice_top import noc_pkg::*; #(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  logic                      clk,
  input  logic                      arst,
  // west input
  input  logic                      valid_w_i,
  input  flit_type_t                ftype_w_i,
  input  vc_id_t                    vc_w_i,
  input  logic [`NOC_X_W-1:0]       xdest_w_i,
  input  logic [`NOC_Y_W-1:0]       ydest_w_i,
  input  logic [`NOC_PAYLOAD_W-1:0] payload_w_i,
  // local input
  input  logic                      valid_loc_i,
  input  flit_type_t                ftype_loc_i,
  input  vc_id_t                    vc_loc_i,
  input  logic [`NOC_X_W-1:0]       xdest_loc_i,
  input  logic [`NOC_Y_W-1:0]       ydest_loc_i,
  input  logic [`NOC_PAYLOAD_W-1:0] payload_loc_i,
  // grant levels back to the sources
  output logic                      grant_w_o,
  output logic                      grant_loc_o,
  // output ports
  output logic                      out_valid_north_o,
  output logic                      out_valid_south_o,
  output logic                      out_valid_west_o,
  output logic                      out_valid_east_o,
  output logic                      out_valid_local_o,
  output vc_id_t                    out_vc_north_o,
  output vc_id_t                    out_vc_south_o,
  output vc_id_t                    out_vc_west_o,
  output vc_id_t                    out_vc_east_o,
  output vc_id_t                    out_vc_local_o,
  output logic [`NOC_PAYLOAD_W-1:0] out_payload_north_o,
  output logic [`NOC_PAYLOAD_W-1:0] out_payload_south_o,
  output logic [`NOC_PAYLOAD_W-1:0] out_payload_west_o,
  output logic [`NOC_PAYLOAD_W-1:0] out_payload_east_o,
  output logic [`NOC_PAYLOAD_W-1:0] out_payload_local_o,
  output logic                      out_src_north_o,
  output logic                      out_src_south_o,
  output logic                      out_src_west_o,
  output logic                      out_src_east_o,
  output logic                      out_src_local_o
);

  // per-input request vectors
  port_req_t req_w;
  port_req_t req_loc;

  // allocator outputs, indexed by port
  port_req_t                              out_valid;
  vc_id_t [N_PORTS-1:0]                   out_vc;
  logic [N_PORTS-1:0][`NOC_PAYLOAD_W-1:0] out_payload;
  logic [N_PORTS-1:0]                     out_src;

  // west input route decode
  input_router #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_rt_w (
    .clk     (clk),
    .arst    (arst),
    .valid_i (valid_w_i),
    .ftype_i (ftype_w_i),
    .vc_i    (vc_w_i),
    .xdest_i (xdest_w_i),
    .ydest_i (ydest_w_i),
    .grant_i (grant_w_o),
    .req_o   (req_w)
  );

  // local input route decode
  input_router #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_rt_loc (
    .clk     (clk),
    .arst    (arst),
    .valid_i (valid_loc_i),
    .ftype_i (ftype_loc_i),
    .vc_i    (vc_loc_i),
    .xdest_i (xdest_loc_i),
    .ydest_i (ydest_loc_i),
    .grant_i (grant_loc_o),
    .req_o   (req_loc)
  );

  // arbitration and output registers
  output_allocator u_alloc (
    .clk           (clk),
    .arst          (arst),
    .req_w_i       (req_w),
    .req_loc_i     (req_loc),
    .vc_w_i        (vc_w_i),
    .vc_loc_i      (vc_loc_i),
    .payload_w_i   (payload_w_i),
    .payload_loc_i (payload_loc_i),
    .grant_w_o     (grant_w_o),
    .grant_loc_o   (grant_loc_o),
    .out_valid_o   (out_valid),
    .out_vc_o      (out_vc),
    .out_payload_o (out_payload),
    .out_src_o     (out_src)
  );

  // split port arrays into named outputs
  assign out_valid_north_o   = out_valid[P_NORTH];
  assign out_valid_south_o   = out_valid[P_SOUTH];
  assign out_valid_west_o    = out_valid[P_WEST];
  assign out_valid_east_o    = out_valid[P_EAST];
  assign out_valid_local_o   = out_valid[P_LOCAL];
  assign out_vc_north_o      = out_vc[P_NORTH];
  assign out_vc_south_o      = out_vc[P_SOUTH];
  assign out_vc_west_o       = out_vc[P_WEST];
  assign out_vc_east_o       = out_vc[P_EAST];
  assign out_vc_local_o      = out_vc[P_LOCAL];
  assign out_payload_north_o = out_payload[P_NORTH];
  assign out_payload_south_o = out_payload[P_SOUTH];
  assign out_payload_west_o  = out_payload[P_WEST];
  assign out_payload_east_o  = out_payload[P_EAST];
  assign out_payload_local_o = out_payload[P_LOCAL];
  assign out_src_north_o     = out_src[P_NORTH];
  assign out_src_south_o     = out_src[P_SOUTH];
  assign out_src_west_o      = out_src[P_WEST];
  assign out_src_east_o      = out_src[P_EAST];
  assign out_src_local_o     = out_src[P_LOCAL];

endmodule
